//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       := icache_tb
RTL_TOP   := icache
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) +incdir+hw \
		hw/icache_pkg.sv hw/icache_if.sv hw/icache_bank.sv hw/fetch_align.sv hw/icache.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/fetch_align.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

// Fetch stage in front of the two banks
// It requests lines k and k+1 and puts the answers back in address order
module fetch_align (
	input wire clk,
	input wire rst,
	input wire ce_i,
	input wire icache_pkg::addr_t pc_i,
	output icache_pkg::line_num_t even_line_o,
	output icache_pkg::line_num_t odd_line_o,
	input wire even_hit_i,
	input wire odd_hit_i,
	input wire icache_pkg::line_data_t even_data_i,
	input wire icache_pkg::line_data_t odd_data_i,
	output icache_pkg::addr_t pc_o,
	output logic hit_o,
	output logic miss_o,
	output icache_pkg::addr_t miss_adr_o,
	output icache_pkg::line_data_t line_lo_o,
	output icache_pkg::line_data_t line_hi_o
);

	// A missed line reads as a run of NOP bytes
	localparam icache_pkg::line_data_t NOP_LINE = {`ICACHE_LINE_BYTES{`ICACHE_NOP}};

	// Even member of the pair {k, k+1}
	function automatic icache_pkg::line_num_t even_of(input icache_pkg::line_num_t k);
		return k[0] ? k + 1'b1 : k;
	endfunction

	// Odd member of the pair, k itself when odd and k+1 otherwise
	function automatic icache_pkg::line_num_t odd_of(input icache_pkg::line_num_t k);
		return {k[$bits(k)-1:1], 1'b1};
	endfunction

	function automatic icache_pkg::addr_t byte_adr_of(input icache_pkg::line_num_t ln);
		return {ln, {`ICACHE_OFF_W{1'b0}}};
	endfunction

	icache_pkg::line_num_t pc_line;
	icache_pkg::line_num_t pc_q_line;
	icache_pkg::line_num_t even_q;
	icache_pkg::line_num_t odd_q;
	icache_pkg::addr_t pc_q;
	logic par_q;
	icache_pkg::line_data_t even_line_data;
	icache_pkg::line_data_t odd_line_data;

	// ======================================================================
	// Request side
	// ======================================================================

	always_comb begin
		pc_line = pc_i[`ICACHE_ADDR_W-1:`ICACHE_OFF_W];
		even_line_o = even_of(pc_line);
		odd_line_o = odd_of(pc_line);
	end

	// The pc and the parity of its line travel alongside the bank reads
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= '0;
			par_q <= 1'b0;
		end else if (ce_i) begin
			pc_q <= pc_i;
			par_q <= pc_line[0];
		end
	end

	// ======================================================================
	// Response side
	// ======================================================================

	always_comb begin
		pc_q_line = pc_q[`ICACHE_ADDR_W-1:`ICACHE_OFF_W];
		even_q = even_of(pc_q_line);
		odd_q = odd_of(pc_q_line);

		even_line_data = even_hit_i ? even_data_i : NOP_LINE;
		odd_line_data = odd_hit_i ? odd_data_i : NOP_LINE;

		// With an odd k the odd bank holds the low line and the even bank the high one
		line_lo_o = par_q ? odd_line_data : even_line_data;
		line_hi_o = par_q ? even_line_data : odd_line_data;

		// An instruction may straddle the pair, so both lines must be present
		hit_o = even_hit_i & odd_hit_i;
		miss_o = ~hit_o;

		// The even line is reported first when both are missing
		if (!even_hit_i) begin
			miss_adr_o = byte_adr_of(even_q);
		end else if (!odd_hit_i) begin
			miss_adr_o = byte_adr_of(odd_q);
		end else begin
			miss_adr_o = '0;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- hw/icache.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

// Two-bank instruction cache returning the line at pc and the line after it
module icache #(
	parameter icache_pkg::cid_t CHANNEL_ID = '0
) (
	input wire clk,
	input wire rst,
	input wire ce_i,
	input wire icache_pkg::addr_t pc_i,
	input wire fill_wr_i,
	input wire icache_pkg::way_t fill_way_i,
	input wire icache_pkg::addr_t fill_adr_i,
	input wire icache_pkg::line_data_t fill_data_i,
	input wire snoop_v_i,
	input wire icache_pkg::addr_t snoop_adr_i,
	input wire icache_pkg::cid_t snoop_cid_i,
	input wire inv_line_i,
	input wire inv_all_i,
	input wire icache_pkg::addr_t inv_adr_i,
	output icache_pkg::addr_t pc_o,
	output logic hit_o,
	output logic miss_o,
	output icache_pkg::addr_t miss_adr_o,
	output icache_pkg::line_data_t line_lo_o,
	output icache_pkg::line_data_t line_hi_o
);

	// Read paths between the aligner and the banks
	icache_pkg::line_num_t even_line;
	icache_pkg::line_num_t odd_line;
	logic even_hit;
	logic odd_hit;
	icache_pkg::line_data_t even_data;
	icache_pkg::line_data_t odd_data;

	// ======================================================================
	// Fill and invalidate buses shared by both banks
	// ======================================================================

	fill_if fill_bus ();
	inval_if inval_bus ();

	// The fill carries a line number, the offset bits are dropped here
	assign fill_bus.wr = fill_wr_i;
	assign fill_bus.way = fill_way_i;
	assign fill_bus.line = fill_adr_i[`ICACHE_ADDR_W-1:`ICACHE_OFF_W];
	assign fill_bus.data = fill_data_i;

	assign inval_bus.snoop_v = snoop_v_i;
	assign inval_bus.snoop_adr = snoop_adr_i;
	assign inval_bus.snoop_cid = snoop_cid_i;
	assign inval_bus.inv_line = inv_line_i;
	assign inval_bus.inv_all = inv_all_i;
	assign inval_bus.inv_adr = inv_adr_i;

	// ======================================================================
	// Banks and fetch stage
	// ======================================================================

	icache_bank #(.BANK(1'b0), .CHANNEL_ID(CHANNEL_ID)) u_bank_even (
		.clk(clk), .rst(rst), .ce_i(ce_i),
		.rd_line_i(even_line),
		.fill(fill_bus), .inval(inval_bus),
		.hit_o(even_hit), .data_o(even_data)
	);

	icache_bank #(.BANK(1'b1), .CHANNEL_ID(CHANNEL_ID)) u_bank_odd (
		.clk(clk), .rst(rst), .ce_i(ce_i),
		.rd_line_i(odd_line),
		.fill(fill_bus), .inval(inval_bus),
		.hit_o(odd_hit), .data_o(odd_data)
	);

	fetch_align u_align (
		.clk(clk), .rst(rst), .ce_i(ce_i),
		.pc_i(pc_i),
		.even_line_o(even_line), .odd_line_o(odd_line),
		.even_hit_i(even_hit), .odd_hit_i(odd_hit),
		.even_data_i(even_data), .odd_data_i(odd_data),
		.pc_o(pc_o), .hit_o(hit_o), .miss_o(miss_o), .miss_adr_o(miss_adr_o),
		.line_lo_o(line_lo_o), .line_hi_o(line_hi_o)
	);

endmodule

`default_nettype wire

//--- hw/icache_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

// One bank of the instruction cache, holding either the even or the odd lines
// Reads are registered under ce, fills and invalidates act every cycle
module icache_bank #(
	parameter bit BANK = 1'b0,
	parameter icache_pkg::cid_t CHANNEL_ID = '0
) (
	input wire clk,
	input wire rst,
	input wire ce_i,
	input wire icache_pkg::line_num_t rd_line_i,
	fill_if.sink fill,
	inval_if.sink inval,
	output logic hit_o,
	output icache_pkg::line_data_t data_o
);

	localparam int LN_W = `ICACHE_ADDR_W - `ICACHE_OFF_W;
	localparam int TAG_LO = `ICACHE_SET_W + 1;

	// Set index of a line number, just above the bank bit
	function automatic icache_pkg::set_t set_of(input icache_pkg::line_num_t ln);
		return ln[`ICACHE_SET_W:1];
	endfunction

	// Tag of a line number
	function automatic icache_pkg::tag_t tag_of(input icache_pkg::line_num_t ln);
		return ln[LN_W-1:TAG_LO];
	endfunction

	// Line number of a byte address
	function automatic icache_pkg::line_num_t line_of(input icache_pkg::addr_t adr);
		return adr[`ICACHE_ADDR_W-1:`ICACHE_OFF_W];
	endfunction

	// ======================================================================
	// Storage
	// ======================================================================

	// Tags and data are plain arrays written only by fills
	icache_pkg::tag_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
	icache_pkg::line_data_t data_mem [`ICACHE_WAYS][`ICACHE_SETS];

	// One valid bit per way and set
	logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];

	// Decoded fields of the read, fill, snoop and invalidate addresses
	icache_pkg::set_t rd_set;
	icache_pkg::tag_t rd_tag;
	icache_pkg::set_t fill_set;
	icache_pkg::tag_t fill_tag;
	icache_pkg::line_num_t snoop_ln;
	icache_pkg::set_t snoop_set;
	icache_pkg::tag_t snoop_tag;
	icache_pkg::line_num_t inv_ln;
	icache_pkg::set_t inv_set;
	icache_pkg::tag_t inv_tag;

	// Requests that concern this bank
	logic fill_we;
	logic snoop_mine;
	logic inv_mine;

	// Per-way results of the three tag compares
	logic [`ICACHE_WAYS-1:0] way_match;
	logic [`ICACHE_WAYS-1:0] snoop_clr;
	logic [`ICACHE_WAYS-1:0] inv_clr;
	icache_pkg::line_data_t rd_data;

	always_comb begin
		rd_set = set_of(rd_line_i);
		rd_tag = tag_of(rd_line_i);
		fill_set = set_of(fill.line);
		fill_tag = tag_of(fill.line);
		snoop_ln = line_of(inval.snoop_adr);
		snoop_set = set_of(snoop_ln);
		snoop_tag = tag_of(snoop_ln);
		inv_ln = line_of(inval.inv_adr);
		inv_set = set_of(inv_ln);
		inv_tag = tag_of(inv_ln);

		// Only lines whose bank bit is ours are filled here
		fill_we = fill.wr && (fill.line[0] == BANK);

		// A snoop raised by our own channel is an echo of our own traffic
		snoop_mine = inval.snoop_v && (inval.snoop_cid != CHANNEL_ID) &&
			(snoop_ln[0] == BANK);
		inv_mine = inval.inv_line && (inv_ln[0] == BANK);
	end

	// ======================================================================
	// Tag compare
	// ======================================================================

	// All ways of the addressed set are checked in parallel
	// The hitting way's data is ORed in, so a miss yields zero
	always_comb begin
		rd_data = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_match[w] = valid_q[w][rd_set] && (tag_mem[w][rd_set] == rd_tag);
			snoop_clr[w] = snoop_mine && (tag_mem[w][snoop_set] == snoop_tag);
			inv_clr[w] = inv_mine && (tag_mem[w][inv_set] == inv_tag);
			if (way_match[w]) begin
				rd_data = rd_data | data_mem[w][rd_set];
			end
		end
	end

	// Registered read result, held while the fetch stage is stalled
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_o <= 1'b0;
		end else if (ce_i) begin
			hit_o <= |way_match;
		end
	end

	always_ff @(posedge clk) begin
		if (ce_i) begin
			data_o <= rd_data;
		end
	end

	// ======================================================================
	// Fill and invalidation
	// ======================================================================

	always_ff @(posedge clk) begin
		if (fill_we) begin
			tag_mem[fill.way][fill_set] <= fill_tag;
			data_mem[fill.way][fill_set] <= fill.data;
		end
	end

	// Each valid bit resolves its own priority
	// A foreign snoop wins over a fill, and a fill wins over a local invalidate
	// inv_all clears every bank regardless of address
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				for (int s = 0; s < `ICACHE_SETS; s++) begin
					if (snoop_clr[w] && (icache_pkg::set_t'(s) == snoop_set)) begin
						valid_q[w][s] <= 1'b0;
					end else if (fill_we && (icache_pkg::way_t'(w) == fill.way) &&
						(icache_pkg::set_t'(s) == fill_set)) begin
						valid_q[w][s] <= 1'b1;
					end else if (inval.inv_all) begin
						valid_q[w][s] <= 1'b0;
					end else if (inv_clr[w] && (icache_pkg::set_t'(s) == inv_set)) begin
						valid_q[w][s] <= 1'b0;
					end
				end
			end
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	// The fill side must never load the same line into two ways of a set
	a_one_way: assert property (@(posedge clk) disable iff (rst)
		ce_i |-> $onehot0(way_match))
		else $error("icache_bank %0d: more than one way hit", BANK);

	// Fills during reset would race the valid clear
	a_no_fill_rst: assert property (@(posedge clk) rst |-> !fill.wr)
		else $error("icache_bank %0d: fill during reset", BANK);

	// The aligner must route each line to the bank that owns it
	a_bank_bit: assert property (@(posedge clk) disable iff (rst)
		ce_i |-> (rd_line_i[0] == BANK))
		else $error("icache_bank %0d: read of a line from the other bank", BANK);

endmodule

`default_nettype wire

//--- hw/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Width of a byte address as seen by the fetch unit
`define ICACHE_ADDR_W 32

// Bytes in one cache line and the offset bits that select a byte in it
`define ICACHE_LINE_BYTES 16
`define ICACHE_OFF_W 4

// Sets in each bank and the index bits that pick one
`define ICACHE_SETS 16
`define ICACHE_SET_W 4

// Associativity of each bank
`define ICACHE_WAYS 4
`define ICACHE_WAY_W 2

// Byte pattern returned for a line whose bank missed
`define ICACHE_NOP 8'h7F

// Channel id width on the snoop bus
`define ICACHE_CID_W 6

`endif

//--- hw/icache_if.sv
`timescale 1ns/10ps
`default_nettype none

// Line fill from the memory side
// A single-cycle strobe writes one way of one set, there is no handshake
interface fill_if;
	logic wr;
	icache_pkg::way_t way;
	icache_pkg::line_num_t line;
	icache_pkg::line_data_t data;

	modport src (output wr, output way, output line, output data);
	modport sink (input wr, input way, input line, input data);
endinterface

// Invalidation requests, both local and snooped from other channels
// The banks do all filtering on channel id and bank bit
interface inval_if;
	logic snoop_v;
	icache_pkg::addr_t snoop_adr;
	icache_pkg::cid_t snoop_cid;
	logic inv_line;
	logic inv_all;
	icache_pkg::addr_t inv_adr;

	modport src (
		output snoop_v, output snoop_adr, output snoop_cid,
		output inv_line, output inv_all, output inv_adr
	);
	modport sink (
		input snoop_v, input snoop_adr, input snoop_cid,
		input inv_line, input inv_all, input inv_adr
	);
endinterface

`default_nettype wire

//--- hw/icache_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

	// Byte address of an instruction fetch or a fill
	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

	// A line number is the byte address with the offset stripped off
	// Bit 0 selects the bank, the set index sits above it, the tag above that
	typedef logic [`ICACHE_ADDR_W-`ICACHE_OFF_W-1:0] line_num_t;

	// Set index within one bank
	typedef logic [`ICACHE_SET_W-1:0] set_t;

	// Tag bits, everything above the bank bit and the set index
	typedef logic [`ICACHE_ADDR_W-`ICACHE_OFF_W-`ICACHE_SET_W-2:0] tag_t;

	// Way index within a set
	typedef logic [`ICACHE_WAY_W-1:0] way_t;

	// Payload of one cache line
	typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_data_t;

	// Channel id carried with a snoop
	typedef logic [`ICACHE_CID_W-1:0] cid_t;

endpackage

`default_nettype wire

//--- src.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_if.sv
hw/icache_bank.sv
hw/fetch_align.sv
hw/icache.sv
verif/icache_tb.sv

//--- verif/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_cfg.svh"

module icache_tb;

	localparam icache_pkg::line_data_t NOP_LINE = {`ICACHE_LINE_BYTES{`ICACHE_NOP}};
	// All tests together take well under two hundred cycles
	localparam int MAX_CYCLES = 2000;

	logic clk;
	logic rst;
	logic ce_i;
	icache_pkg::addr_t pc_i;
	logic fill_wr_i;
	icache_pkg::way_t fill_way_i;
	icache_pkg::addr_t fill_adr_i;
	icache_pkg::line_data_t fill_data_i;
	logic snoop_v_i;
	icache_pkg::addr_t snoop_adr_i;
	icache_pkg::cid_t snoop_cid_i;
	logic inv_line_i;
	logic inv_all_i;
	icache_pkg::addr_t inv_adr_i;
	icache_pkg::addr_t pc_o;
	logic hit_o;
	logic miss_o;
	icache_pkg::addr_t miss_adr_o;
	icache_pkg::line_data_t line_lo_o;
	icache_pkg::line_data_t line_hi_o;

	// Reference model, indexed by bank bit, way and set
	// Line number map: bank bit 0, set in bits 4:1, tag in bits 27:5
	logic m_valid [2][`ICACHE_WAYS][`ICACHE_SETS];
	icache_pkg::tag_t m_tag [2][`ICACHE_WAYS][`ICACHE_SETS];
	icache_pkg::line_data_t m_data [2][`ICACHE_WAYS][`ICACHE_SETS];

	icache_pkg::line_num_t pair_a;
	icache_pkg::line_num_t pair_b;
	int cycles = 0;

	icache #(.CHANNEL_ID(6'd5)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Test failed");
			$fatal(1, "timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		end
	end

	// ======================================================================
	// Model and checking helpers
	// ======================================================================

	task automatic compare(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			$display("Test failed");
			$fatal(1, "mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Random line number in a chosen set of a chosen bank
	function automatic icache_pkg::line_num_t rand_line(input icache_pkg::set_t s, input logic b);
		return {icache_pkg::tag_t'($urandom), s, b};
	endfunction

	// A line that is not present reads as NOP bytes
	task automatic lookup(input icache_pkg::line_num_t ln, output logic hit,
		output icache_pkg::line_data_t data);
		hit = 1'b0;
		data = NOP_LINE;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (m_valid[ln[0]][w][ln[4:1]] && (m_tag[ln[0]][w][ln[4:1]] == ln[27:5])) begin
				hit = 1'b1;
				data = m_data[ln[0]][w][ln[4:1]];
			end
		end
	endtask

	// Clear every way of the line's set whose tag matches
	task automatic drop_line(input icache_pkg::line_num_t ln);
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (m_tag[ln[0]][w][ln[4:1]] == ln[27:5]) begin
				m_valid[ln[0]][w][ln[4:1]] = 1'b0;
			end
		end
	endtask

	task automatic fill_line(input icache_pkg::line_num_t ln, input icache_pkg::way_t way);
		icache_pkg::line_data_t d;
		d = {$urandom, $urandom, $urandom, $urandom};
		fill_wr_i = 1'b1;
		fill_way_i = way;
		fill_adr_i = {ln, 4'h0};
		fill_data_i = d;
		@(negedge clk);
		fill_wr_i = 1'b0;
		m_valid[ln[0]][way][ln[4:1]] = 1'b1;
		m_tag[ln[0]][way][ln[4:1]] = ln[27:5];
		m_data[ln[0]][way][ln[4:1]] = d;
	endtask

	task automatic invalidate(input logic all, input icache_pkg::line_num_t ln);
		inv_all_i = all;
		inv_line_i = !all;
		inv_adr_i = {ln, 4'hA};
		@(negedge clk);
		inv_all_i = 1'b0;
		inv_line_i = 1'b0;
		if (all) begin
			m_valid = '{default: 1'b0};
		end else begin
			drop_line(ln);
		end
	endtask

	// Snoops from the cache's own channel leave the model alone
	task automatic snoop(input icache_pkg::line_num_t ln, input icache_pkg::cid_t cid);
		snoop_v_i = 1'b1;
		snoop_adr_i = {ln, 4'h2};
		snoop_cid_i = cid;
		@(negedge clk);
		snoop_v_i = 1'b0;
		if (cid != 6'd5) begin
			drop_line(ln);
		end
	endtask

	// One fetch with ce high, checked against the model one cycle later
	task automatic fetch_check(input string name, input icache_pkg::addr_t pc);
		icache_pkg::line_num_t k;
		logic lo_hit;
		logic hi_hit;
		icache_pkg::line_data_t lo_data;
		icache_pkg::line_data_t hi_data;
		icache_pkg::addr_t exp_miss;
		pc_i = pc;
		ce_i = 1'b1;
		@(negedge clk);
		ce_i = 1'b0;
		k = pc[31:4];
		lookup(k, lo_hit, lo_data);
		lookup(k + 28'd1, hi_hit, hi_data);
		// When both lines miss the even one of the pair is reported
		if (!lo_hit && (hi_hit || !k[0])) begin
			exp_miss = {k, 4'h0};
		end else if (!hi_hit) begin
			exp_miss = {k + 28'd1, 4'h0};
		end else begin
			exp_miss = '0;
		end
		compare(name, pc, pc_o);
		compare(name, lo_hit && hi_hit, hit_o);
		compare(name, !(lo_hit && hi_hit), miss_o);
		compare(name, exp_miss, miss_adr_o);
		compare(name, lo_data, line_lo_o);
		compare(name, hi_data, line_hi_o);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic check_reset();
		compare("reset", '0, pc_o);
		compare("reset", 1'b0, hit_o);
		compare("reset", 1'b1, miss_o);
		compare("reset", NOP_LINE, line_lo_o);
		compare("reset", NOP_LINE, line_hi_o);
		fetch_check("reset", $urandom);
		fetch_check("reset", $urandom);
	endtask

	// The odd pair starts in set 15, so its high line wraps to set 0 of the even bank
	task automatic check_fill_pairs();
		pair_a = rand_line(4'd6, 1'b0);
		fill_line(pair_a, 2'd0);
		fill_line(pair_a + 28'd1, 2'd1);
		pair_b = rand_line(4'd15, 1'b1);
		fill_line(pair_b, 2'd2);
		fill_line(pair_b + 28'd1, 2'd3);
		fetch_check("fill_pairs", {pair_a, 4'h0});
		fetch_check("fill_pairs", {pair_a, 4'h9});
		fetch_check("fill_pairs", {pair_b, 4'h3});
		fetch_check("fill_pairs", {pair_b, 4'hF});
	endtask

	task automatic check_partial();
		icache_pkg::line_num_t k;
		k = rand_line(4'd3, 1'b0);
		fill_line(k + 28'd1, 2'd0);
		fetch_check("partial", {k, 4'h5});
		compare("partial", {k, 4'h0}, miss_adr_o);
		k = rand_line(4'd9, 1'b1);
		fill_line(k, 2'd1);
		fetch_check("partial", {k, 4'hC});
		fetch_check("partial", {rand_line(4'd12, 1'b1), 4'h1});
	endtask

	task automatic check_invalidate();
		invalidate(1'b0, pair_a);
		fetch_check("invalidate", {pair_a, 4'h4});
		fetch_check("invalidate", {pair_b, 4'h4});
		invalidate(1'b1, '0);
		fetch_check("invalidate", {pair_b, 4'h8});
		fetch_check("invalidate", {pair_a, 4'h8});
	endtask

	// Two pairs share set 11 in each bank, one way each
	task automatic check_snoop();
		icache_pkg::line_num_t k;
		k = rand_line(4'd11, 1'b0);
		pair_b = rand_line(4'd11, 1'b0);
		fill_line(k, 2'd0);
		fill_line(k + 28'd1, 2'd0);
		fill_line(pair_b, 2'd1);
		fill_line(pair_b + 28'd1, 2'd1);
		snoop(k, 6'd5);
		fetch_check("snoop", {k, 4'h6});
		snoop(k, 6'd9);
		fetch_check("snoop", {k, 4'h6});
		fetch_check("snoop", {pair_b, 4'h6});
	endtask

	// The pair in pair_b is even, so its low line sits in the even bank
	task automatic check_stall();
		icache_pkg::addr_t pc;
		logic lo_hit;
		logic hi_hit;
		icache_pkg::line_data_t lo_data;
		icache_pkg::line_data_t hi_data;
		icache_pkg::addr_t exp_miss;
		pc = {pair_b, 4'h2};
		lookup(pair_b, lo_hit, lo_data);
		lookup(pair_b + 28'd1, hi_hit, hi_data);
		if (!lo_hit) begin
			exp_miss = {pair_b, 4'h0};
		end else if (!hi_hit) begin
			exp_miss = {pair_b + 28'd1, 4'h0};
		end else begin
			exp_miss = '0;
		end
		fetch_check("stall", pc);
		repeat (4) begin
			pc_i = $urandom;
			@(negedge clk);
			// Every output keeps the answer for the last fetch taken with ce high
			compare("stall", pc, pc_o);
			compare("stall", lo_hit && hi_hit, hit_o);
			compare("stall", !(lo_hit && hi_hit), miss_o);
			compare("stall", exp_miss, miss_adr_o);
			compare("stall", lo_data, line_lo_o);
			compare("stall", hi_data, line_hi_o);
		end
		fetch_check("stall", {pair_a, 4'hE});
	endtask

	initial begin
		void'($urandom(39482));
		rst = 1'b1;
		ce_i = 1'b0;
		pc_i = '0;
		fill_wr_i = 1'b0;
		fill_way_i = '0;
		fill_adr_i = '0;
		fill_data_i = '0;
		snoop_v_i = 1'b0;
		snoop_adr_i = '0;
		snoop_cid_i = '0;
		inv_line_i = 1'b0;
		inv_all_i = 1'b0;
		inv_adr_i = '0;
		m_valid = '{default: 1'b0};
		repeat (4) @(negedge clk);
		rst = 1'b0;
		check_reset();
		check_fill_pairs();
		check_partial();
		check_invalidate();
		check_snoop();
		check_stall();
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
